//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       ?= tb_hart
FILELIST  ?= all.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

//--- all.f
src/hart_pkg.sv
src/hart_regfile.sv
src/hart_decode.sv
src/hart_execute.sv
src/hart_result.sv
src/hart_top.sv
sim/tb_hart.sv

//--- sim/tb_hart.sv
`timescale 1ns/1ps

module tb_hart;
    import hart_pkg::*;

    localparam word_t RESET_ADDR = 32'h0000_0040;
    localparam int    N_PROG     = 200;
    localparam int    PROG2_LEN  = 3;
    // Both programs and both resets with their idle cycles and a margin
    localparam int    WATCH_CYCLES = N_PROG + 1 + PROG2_LEN + 2 * (4 + 10 + 1) + 20;

    typedef struct packed {
        logic      trap;
        logic      halt;
        word_t     next_pc;
        reg_addr_t rd;
        word_t     wdata;
        logic      dren;
        logic      dwen;
        word_t     daddr;
        word_t     dwdata;
    } expect_t;

    logic      clk;
    logic      rst;
    word_t     imem_raddr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
    logic      dmem_ren, dmem_wen;
    logic      ret_valid, ret_trap, ret_halt;
    word_t     ret_inst, ret_pc, ret_next_pc, ret_rd_wdata;
    reg_addr_t ret_rd_waddr;

    word_t  imem [256];
    word_t  dmem [64];
    // Architectural model state
    word_t  mpc;
    word_t  mreg [32];
    word_t  mdm [64];
    integer seed = 51;

    hart_top #(.RESET_ADDR(RESET_ADDR)) dut_i (
        .i_clk             (clk),
        .i_rst             (rst),
        .o_imem_raddr      (imem_raddr),
        .i_imem_rdata      (imem_rdata),
        .o_dmem_addr       (dmem_addr),
        .o_dmem_ren        (dmem_ren),
        .o_dmem_wen        (dmem_wen),
        .o_dmem_wdata      (dmem_wdata),
        .i_dmem_rdata      (dmem_rdata),
        .o_retire_valid    (ret_valid),
        .o_retire_trap     (ret_trap),
        .o_retire_halt     (ret_halt),
        .o_retire_inst     (ret_inst),
        .o_retire_pc       (ret_pc),
        .o_retire_next_pc  (ret_next_pc),
        .o_retire_rd_waddr (ret_rd_waddr),
        .o_retire_rd_wdata (ret_rd_wdata)
    );

    ////////////////////
    // Clock and memories
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign imem_rdata = imem[imem_raddr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    initial begin
        #(WATCH_CYCLES * 100);
        $display("Timeout: the hart did not halt in time");
        $display("test failed");
        $fatal(1);
    end

    ////////////////////
    // Encoders and reference model
    ////////////////////

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Steps the model by one instruction and returns the retire fields
    function automatic expect_t ref_step(input word_t inst);
        expect_t    e;
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a, b, imm_i, imm_s, imm_b, imm_u, imm_j, wb;
        logic       wr, taken;
        f3    = inst[14:12];
        rd    = inst[11:7];
        a     = mreg[inst[19:15]];
        b     = mreg[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        e = '0;
        e.next_pc = mpc + 32'd4;
        wr = 1'b0;
        wb = '0;
        taken = 1'b0;
        case (inst[6:0])
            7'h33: begin
                wr = 1'b1;
                wb = alu_ref(f3, inst[30], a, b);
            end
            7'h13: begin
                wr = 1'b1;
                wb = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
            end
            7'h37: begin
                wr = 1'b1;
                wb = imm_u;
            end
            7'h17: begin
                wr = 1'b1;
                wb = mpc + imm_u;
            end
            7'h6f: begin
                wr        = 1'b1;
                wb        = mpc + 32'd4;
                e.next_pc = mpc + imm_j;
            end
            7'h67: begin
                wr        = 1'b1;
                wb        = mpc + 32'd4;
                e.next_pc = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0:    taken = a == b;
                    3'd1:    taken = a != b;
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) e.next_pc = mpc + imm_b;
            end
            7'h03: begin
                e.dren  = 1'b1;
                e.daddr = (a + imm_i) & ~32'd3;
                wr      = 1'b1;
                wb      = mdm[e.daddr[7:2]];
            end
            7'h23: begin
                e.dwen   = 1'b1;
                e.daddr  = (a + imm_s) & ~32'd3;
                e.dwdata = b;
                mdm[e.daddr[7:2]] = b;
            end
            7'h73: begin
                if (inst == 32'h0010_0073) e.halt = 1'b1;
                else e.trap = 1'b1;
            end
            default: e.trap = 1'b1;
        endcase
        if (wr && rd != 5'd0) begin
            e.rd     = rd;
            e.wdata  = wb;
            mreg[rd] = wb;
        end
        if (!e.halt && !e.trap) mpc = e.next_pc;
        return e;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic fail_value(input string name, input word_t got, input word_t exp);
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else fail_value(name, got, exp);
    endtask

    task automatic check_idle(input string when);
        assert (!ret_valid && !dmem_ren && !dmem_wen)
            else fail_plain({"Retire valid or a memory strobe is high ", when});
    endtask

    task automatic build_program();
        int        idx;
        int        kind;
        logic [2:0] f3;
        reg_addr_t rd, rs1, rs2;
        logic [11:0] imm;
        logic [7:0]  off;
        idx = 0;
        while (idx < N_PROG) begin
            kind = $unsigned($random(seed)) % 10;
            f3   = $random(seed);
            rd   = $random(seed);
            rs1  = $random(seed);
            rs2  = $random(seed);
            imm  = $random(seed);
            off  = {$random(seed)} % 64 * 4;
            if (kind >= 6 && idx > N_PROG - 4) kind = 3;
            case (kind)
                0, 1, 2: begin
                    imem[RESET_ADDR[9:2] + idx] = {1'b0, imm[0] && (f3 == 0 || f3 == 5),
                                                   5'd0, rs2, rs1, f3, rd, 7'h33};
                    idx++;
                end
                3, 4: begin
                    if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
                    if (f3 == 3'd5) imm = {1'b0, imm[10], 5'd0, imm[4:0]};
                    imem[RESET_ADDR[9:2] + idx] = enc_i(imm, rs1, f3, rd, 7'h13);
                    idx++;
                end
                5: begin
                    imem[RESET_ADDR[9:2] + idx] = {imm, rs1, rs2[4:2],
                                                   rd, imm[0] ? 7'h37 : 7'h17};
                    idx++;
                end
                6: begin
                    // Store then load back the same word
                    imem[RESET_ADDR[9:2] + idx] = {4'd0, off[7:5], rs2, 5'd0, 3'b010,
                                                   off[4:0], 7'h23};
                    imem[RESET_ADDR[9:2] + idx + 1] = enc_i({4'd0, off}, 5'd0, 3'b010,
                                                            rd, 7'h03);
                    idx += 2;
                end
                7: begin
                    f3 = {$unsigned($random(seed)) % 6};
                    if (f3 >= 3'd2) f3 = f3 + 3'd2;
                    imem[RESET_ADDR[9:2] + idx] = enc_b(imm[0] ? 13'd8 : 13'd12, rs2, rs1, f3);
                    idx++;
                end
                8: begin
                    imem[RESET_ADDR[9:2] + idx] = enc_j(imm[0] ? 21'd8 : 21'd12, rd);
                    idx++;
                end
                default: begin
                    // The odd JALR target checks that bit 0 is cleared
                    imem[RESET_ADDR[9:2] + idx]     = {20'd0, 5'd31, 7'h17};
                    imem[RESET_ADDR[9:2] + idx + 1] =
                        enc_i(12'(RESET_ADDR + 4 * (idx + 3) + 1), 5'd0, 3'd0, rd, 7'h67);
                    imem[RESET_ADDR[9:2] + idx + 2] = enc_i(imm, rs1, 3'd0, rd, 7'h13);
                    idx += 3;
                end
            endcase
        end
        imem[RESET_ADDR[9:2] + N_PROG] = 32'h0010_0073;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 rst = 1'b1;
        for (int n = 0; n < 4; n++) begin
            @(negedge clk);
            check_idle("during reset");
            // The PC loads at the first reset edge
            if (n > 0) check_word("retire_pc", ret_pc, RESET_ADDR);
        end
        @(posedge clk);
        #1 rst = 1'b0;
        mpc = RESET_ADDR;
        for (int n = 0; n < 32; n++) mreg[n] = '0;
    endtask

    task automatic run_to_halt();
        expect_t e;
        logic    done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            assert (ret_valid) else fail_plain("Retire valid dropped before a halt");
            check_word("imem_raddr", imem_raddr, mpc);
            check_word("retire_pc", ret_pc, mpc);
            check_word("retire_inst", ret_inst, imem[mpc[9:2]]);
            e = ref_step(imem[mpc[9:2]]);
            check_word("retire_trap", 32'(ret_trap), 32'(e.trap));
            check_word("retire_halt", 32'(ret_halt), 32'(e.halt));
            check_word("retire_next_pc", ret_next_pc, e.next_pc);
            check_word("retire_rd_waddr", 32'(ret_rd_waddr), 32'(e.rd));
            check_word("retire_rd_wdata", ret_rd_wdata, e.wdata);
            check_word("dmem_ren", 32'(dmem_ren), 32'(e.dren));
            check_word("dmem_wen", 32'(dmem_wen), 32'(e.dwen));
            if (e.dren || e.dwen) check_word("dmem_addr", dmem_addr, e.daddr);
            if (e.dwen) check_word("dmem_wdata", dmem_wdata, e.dwdata);
            done = e.halt || e.trap;
        end
        // The PC holds at the halting instruction
        repeat (10) begin
            @(negedge clk);
            check_idle("after the halt");
            check_word("retire_pc", ret_pc, mpc);
            check_word("imem_raddr", imem_raddr, mpc);
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int n = 0; n < 256; n++) imem[n] = enc_i(12'(n), 5'd0, 3'd0, 5'd0, 7'h13);
        for (int n = 0; n < 64; n++) begin
            dmem[n] = 32'hd000_0000 | (n * 32'h0001_0101);
            mdm[n]  = dmem[n];
        end
        build_program();
        apply_reset();
        run_to_halt();
        // Short second program ending in an unknown opcode with rd set
        imem[RESET_ADDR[9:2]]     = enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13);
        imem[RESET_ADDR[9:2] + 1] = enc_i(12'd3, 5'd1, 3'd0, 5'd2, 7'h13);
        imem[RESET_ADDR[9:2] + 2] = 32'h0012_30ff;
        apply_reset();
        run_to_halt();
        $display("test passed");
        $finish;
    end

endmodule

//--- src/hart_decode.sv
`timescale 1ns/1ps

module hart_decode (
    input  hart_pkg::inst_t     i_inst,
    output hart_pkg::ctrl_t     o_ctrl,
    output hart_pkg::word_t     o_imm,
    output hart_pkg::reg_addr_t o_rs1_addr,
    output hart_pkg::reg_addr_t o_rs2_addr
);
    import hart_pkg::*;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // Maps funct3 to the ALU operation
    // The alt bit picks SUB or SRA
    function automatic alu_op_t funct_to_alu(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign o_rs1_addr = i_inst.r.rs1;
    assign o_rs2_addr = i_inst.r.rs2;

    ////////////////////
    // Control fields
    ////////////////////

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.alu_op = ADD;
        o_ctrl.funct3 = i_inst.r.funct3;
        o_ctrl.rd     = i_inst.r.rd;
        case (i_inst.r.opcode)
            OP: begin
                o_ctrl.alu_op    = funct_to_alu(i_inst.r.funct3, i_inst.r.funct7[5]);
                o_ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                // Only shifts read bit 30 as a selector
                o_ctrl.alu_op    = funct_to_alu(i_inst.i.funct3,
                                                (i_inst.i.funct3 == 3'b101) &&
                                                i_inst.r.funct7[5]);
                o_ctrl.op2_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            LUI: begin
                o_ctrl.op1_zero  = 1'b1;
                o_ctrl.op2_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            AUIPC: begin
                o_ctrl.op1_pc    = 1'b1;
                o_ctrl.op2_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            JAL: begin
                // op1_pc tells execute this is JAL rather than JALR
                o_ctrl.op1_pc    = 1'b1;
                o_ctrl.op2_imm   = 1'b1;
                o_ctrl.jump      = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            JALR: begin
                o_ctrl.op2_imm   = 1'b1;
                o_ctrl.jump      = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            BRANCH: o_ctrl.branch = 1'b1;
            LOAD: begin
                o_ctrl.op2_imm   = 1'b1;
                o_ctrl.mem_read  = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            STORE: begin
                o_ctrl.op2_imm   = 1'b1;
                o_ctrl.mem_write = 1'b1;
            end
            SYSTEM: begin
                // EBREAK halts and any other system encoding traps
                if (i_inst == EBREAK_WORD) begin
                    o_ctrl.halt = 1'b1;
                end else begin
                    o_ctrl.trap = 1'b1;
                end
            end
            default: o_ctrl.trap = 1'b1;
        endcase
    end

    ////////////////////
    // Immediate
    ////////////////////

    always_comb begin
        case (i_inst.r.opcode)
            STORE:       o_imm = {{20{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5,
                                  i_inst.s.imm_4_0};
            BRANCH:      o_imm = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
            LUI, AUIPC:  o_imm = {i_inst.u.imm_31_12, 12'h000};
            JAL:         o_imm = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};
            default:     o_imm = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
        endcase
    end

    // Every format keeps the immediate sign in instruction bit 31
    a_imm_sign: assert property (@(i_inst) o_imm[31] == i_inst.r.funct7[6]);

endmodule

//--- src/hart_execute.sv
`timescale 1ns/1ps

module hart_execute (
    input  hart_pkg::ctrl_t i_ctrl,
    input  hart_pkg::word_t i_pc,
    input  hart_pkg::word_t i_imm,
    input  hart_pkg::word_t i_rs1_data,
    input  hart_pkg::word_t i_rs2_data,
    output hart_pkg::exec_t o_exec
);
    import hart_pkg::*;

    word_t op1;
    word_t op2;
    word_t alu_out;
    word_t pc_target;
    logic  [4:0] shamt;
    logic  taken;

    ////////////////////
    // Operand select and ALU
    ////////////////////

    always_comb begin
        if (i_ctrl.op1_zero) begin
            op1 = '0;
        end else if (i_ctrl.op1_pc) begin
            op1 = i_pc;
        end else begin
            op1 = i_rs1_data;
        end
    end

    assign op2   = i_ctrl.op2_imm ? i_imm : i_rs2_data;
    assign shamt = op2[4:0];

    always_comb begin
        case (i_ctrl.alu_op)
            ADD:     alu_out = op1 + op2;
            SUB:     alu_out = op1 - op2;
            SLL:     alu_out = op1 << shamt;
            SLT:     alu_out = {31'd0, $signed(op1) < $signed(op2)};
            SLTU:    alu_out = {31'd0, op1 < op2};
            XOR:     alu_out = op1 ^ op2;
            SRL:     alu_out = op1 >> shamt;
            SRA:     alu_out = $unsigned($signed(op1) >>> shamt);
            OR:      alu_out = op1 | op2;
            default: alu_out = op1 & op2;
        endcase
    end

    ////////////////////
    // Branch compare
    ////////////////////

    always_comb begin
        case (i_ctrl.funct3)
            3'b000:  taken = i_rs1_data == i_rs2_data;
            3'b001:  taken = i_rs1_data != i_rs2_data;
            3'b100:  taken = $signed(i_rs1_data) < $signed(i_rs2_data);
            3'b101:  taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
            3'b110:  taken = i_rs1_data < i_rs2_data;
            3'b111:  taken = i_rs1_data >= i_rs2_data;
            default: taken = 1'b0;
        endcase
    end

    // Next PC
    assign pc_target = i_pc + i_imm;

    always_comb begin
        o_exec.alu_result = alu_out;
        o_exec.pc_plus4   = i_pc + 32'd4;
        if ((i_ctrl.branch && taken) || (i_ctrl.jump && i_ctrl.op1_pc)) begin
            o_exec.next_pc = pc_target;
        end else if (i_ctrl.jump) begin
            o_exec.next_pc = {alu_out[31:1], 1'b0};
        end else begin
            o_exec.next_pc = o_exec.pc_plus4;
        end
    end

endmodule

//--- src/hart_pkg.sv
package hart_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

    ////////////////////
    // Opcodes and ALU operations
    ////////////////////

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    ////////////////////
    // Instruction word views
    ////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        opcode_t     opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_t    opcode;
    } inst_j_t;

    // Same 32-bit word, one field map per format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_t;

    ////////////////////
    // Control and execute bundles
    ////////////////////

    typedef struct packed {
        alu_op_t    alu_op;
        logic       op1_pc;
        logic       op1_zero;
        logic       op2_imm;
        logic       branch;
        logic       jump;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       halt;
        logic       trap;
        logic [2:0] funct3;
        reg_addr_t  rd;
    } ctrl_t;

    typedef struct packed {
        word_t alu_result;
        word_t pc_plus4;
        word_t next_pc;
    } exec_t;

endpackage

//--- src/hart_regfile.sv
`timescale 1ns/1ps

module hart_regfile (
    input  logic              i_clk,
    input  logic              i_rst,
    input  hart_pkg::reg_addr_t i_rs1_addr,
    input  hart_pkg::reg_addr_t i_rs2_addr,
    input  logic              i_wen,
    input  hart_pkg::reg_addr_t i_rd_addr,
    input  hart_pkg::word_t   i_rd_data,
    output hart_pkg::word_t   o_rs1_data,
    output hart_pkg::word_t   o_rs2_data
);
    import hart_pkg::*;

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (i_wen && (i_rd_addr != 5'd0)) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // Reads are combinational, no bypass of the write in flight
    always_comb begin
        o_rs1_data = '0;
        o_rs2_data = '0;
        if (i_rs1_addr != 5'd0) begin
            o_rs1_data = regs[i_rs1_addr];
        end
        if (i_rs2_addr != 5'd0) begin
            o_rs2_data = regs[i_rs2_addr];
        end
    end

endmodule

//--- src/hart_result.sv
`timescale 1ns/1ps

module hart_result (
    input  hart_pkg::ctrl_t     i_ctrl,
    input  hart_pkg::exec_t     i_exec,
    input  hart_pkg::word_t     i_store_data,
    input  hart_pkg::word_t     i_dmem_rdata,
    output hart_pkg::word_t     o_dmem_addr,
    output logic                o_dmem_ren_raw,
    output logic                o_dmem_wen_raw,
    output hart_pkg::word_t     o_dmem_wdata,
    output logic                o_rd_wen,
    output hart_pkg::reg_addr_t o_rd_addr,
    output hart_pkg::word_t     o_rd_data
);
    import hart_pkg::*;

    word_t wb_value;

    ////////////////////
    // Data memory
    ////////////////////

    // Word access only, low address bits dropped
    assign o_dmem_addr    = {i_exec.alu_result[31:2], 2'b00};
    assign o_dmem_ren_raw = i_ctrl.mem_read;
    assign o_dmem_wen_raw = i_ctrl.mem_write;
    assign o_dmem_wdata   = i_store_data;

    ////////////////////
    // Write-back
    ////////////////////

    always_comb begin
        if (i_ctrl.jump) begin
            wb_value = i_exec.pc_plus4;
        end else if (i_ctrl.mem_read) begin
            wb_value = i_dmem_rdata;
        end else begin
            wb_value = i_exec.alu_result;
        end
    end

    // No write shows as rd zero with zero data
    assign o_rd_wen  = i_ctrl.reg_write && (i_ctrl.rd != 5'd0);
    assign o_rd_addr = o_rd_wen ? i_ctrl.rd : 5'd0;
    assign o_rd_data = o_rd_wen ? wb_value : '0;

    a_strobe_excl: assert property (@(i_ctrl) !(o_dmem_ren_raw && o_dmem_wen_raw));

endmodule

//--- src/hart_top.sv
`timescale 1ns/1ps

module hart_top #(
    parameter hart_pkg::word_t RESET_ADDR = hart_pkg::RESET_PC_DEFAULT
) (
    input  logic                i_clk,
    input  logic                i_rst,
    output hart_pkg::word_t     o_imem_raddr,
    input  hart_pkg::word_t     i_imem_rdata,
    output hart_pkg::word_t     o_dmem_addr,
    output logic                o_dmem_ren,
    output logic                o_dmem_wen,
    output hart_pkg::word_t     o_dmem_wdata,
    input  hart_pkg::word_t     i_dmem_rdata,
    output logic                o_retire_valid,
    output logic                o_retire_trap,
    output logic                o_retire_halt,
    output hart_pkg::word_t     o_retire_inst,
    output hart_pkg::word_t     o_retire_pc,
    output hart_pkg::word_t     o_retire_next_pc,
    output hart_pkg::reg_addr_t o_retire_rd_waddr,
    output hart_pkg::word_t     o_retire_rd_wdata
);
    import hart_pkg::*;

    word_t     pc;
    logic      halted;
    logic      valid;
    inst_t     inst;
    ctrl_t     ctrl;
    word_t     imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    exec_t     exec;
    logic      ren_raw;
    logic      wen_raw;
    logic      rd_wen;
    reg_addr_t rd_addr;
    word_t     rd_data;

    ////////////////////
    // PC and halt state
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc     <= RESET_ADDR;
            halted <= 1'b0;
        end else if (!halted) begin
            if (ctrl.halt || ctrl.trap) begin
                halted <= 1'b1;
            end else begin
                pc <= exec.next_pc;
            end
        end
    end

    assign valid = !i_rst && !halted;
    assign inst  = i_imem_rdata;

    hart_decode u_decode (
        .i_inst     (inst),
        .o_ctrl     (ctrl),
        .o_imm      (imm),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr)
    );

    hart_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wen      (rd_wen && valid),
        .i_rd_addr  (rd_addr),
        .i_rd_data  (rd_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    hart_execute u_execute (
        .i_ctrl     (ctrl),
        .i_pc       (pc),
        .i_imm      (imm),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_exec     (exec)
    );

    hart_result u_result (
        .i_ctrl         (ctrl),
        .i_exec         (exec),
        .i_store_data   (rs2_data),
        .i_dmem_rdata   (i_dmem_rdata),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_ren_raw (ren_raw),
        .o_dmem_wen_raw (wen_raw),
        .o_dmem_wdata   (o_dmem_wdata),
        .o_rd_wen       (rd_wen),
        .o_rd_addr      (rd_addr),
        .o_rd_data      (rd_data)
    );

    ////////////////////
    // External ports
    ////////////////////

    assign o_imem_raddr      = pc;
    assign o_dmem_ren        = ren_raw && valid;
    assign o_dmem_wen        = wen_raw && valid;
    assign o_retire_valid    = valid;
    assign o_retire_trap     = ctrl.trap && valid;
    assign o_retire_halt     = ctrl.halt && valid;
    assign o_retire_inst     = i_imem_rdata;
    assign o_retire_pc       = pc;
    assign o_retire_next_pc  = exec.next_pc;
    assign o_retire_rd_waddr = rd_addr;
    assign o_retire_rd_wdata = rd_data;

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) pc[1:0] == 2'b00);

endmodule
